/* source/permutePipe_macros.svh */
`ifndef PERMUTEPIPE_MACROS_SVH
`define PERMUTEPIPE_MACROS_SVH

// Truth table of a monotone function of seven variables
`define BOT_WIDTH 128

// Running totals per top
`define SUM_WIDTH 48
`define COUNT_WIDTH 13

// Orderings of variables 4, 5 and 6
`define PERM_COUNT 6
// One item adds at most 6 x 128
`define ITEM_SUM_WIDTH 11

`endif

/* source/permutePipePkg.sv */
`include "permutePipe_macros.svh"

package permutePipePkg;

    // Source variable placed on positions 4, 5, 6 in turn
    typedef enum logic [2:0] {
        PERM_456,
        PERM_465,
        PERM_546,
        PERM_564,
        PERM_645,
        PERM_654
    } permOrder;

    // Stage 1 to stage 2
    typedef struct packed {
        logic [`PERM_COUNT-1:0][`BOT_WIDTH-1:0] bots;
        logic [`BOT_WIDTH-1:0] top;
        logic startNewTop;
    } permutedItem;

    // Stage 2 to stage 3, counts 0 to 6 need three bits
    typedef struct packed {
        logic [`ITEM_SUM_WIDTH-1:0] itemSum;
        logic [$clog2(`PERM_COUNT + 1)-1:0] itemCount;
        logic startNewTop;
    } countedItem;

endpackage

/* source/permuteBus.sv */
`timescale 1ns/10ps

// One pipeline item moving between two stages
interface permuteBus #(
    parameter type payloadType = logic
) (
    // Shared stall control from the output stage
    input logic advance
);

    logic valid;
    payloadType payload;

    // Producing stage
    modport source (
        output valid,
        output payload,
        input advance
    );

    // Consuming stage
    modport sink (
        input valid,
        input payload,
        input advance
    );

endinterface

/* source/variablePermuter.sv */
`timescale 1ns/10ps
`include "permutePipe_macros.svh"

module variablePermuter (
    input logic clock,
    input logic rst,
    input logic inValid,
    input logic startNewTop,
    input logic [`BOT_WIDTH-1:0] bot,
    permuteBus.source outBus
);

    logic accept;
    logic validReg;
    logic [`BOT_WIDTH-1:0] topReg;
    logic [`BOT_WIDTH-1:0] nextTop;
    logic [`PERM_COUNT-1:0][`BOT_WIDTH-1:0] permuted;
    permutePipePkg::permutedItem itemReg;

    // Source bit index for one output bit, bits 3:0 pass straight
    function automatic logic [6:0] sourceIndex(
        input logic [6:0] idx,
        input permutePipePkg::permOrder order
    );
        case (order)
            permutePipePkg::PERM_465: return {idx[5], idx[6], idx[4], idx[3:0]};
            permutePipePkg::PERM_546: return {idx[6], idx[4], idx[5], idx[3:0]};
            permutePipePkg::PERM_564: return {idx[5], idx[4], idx[6], idx[3:0]};
            permutePipePkg::PERM_645: return {idx[4], idx[6], idx[5], idx[3:0]};
            permutePipePkg::PERM_654: return {idx[4], idx[5], idx[6], idx[3:0]};
            default: return idx;
        endcase
    endfunction

    function automatic logic [`BOT_WIDTH-1:0] permuteBot(
        input logic [`BOT_WIDTH-1:0] source,
        input permutePipePkg::permOrder order
    );
        logic [`BOT_WIDTH-1:0] result;
        for (int i = 0; i < `BOT_WIDTH; i++) begin
            result[i] = source[sourceIndex(7'(i), order)];
        end
        return result;
    endfunction

    assign accept = inValid && outBus.advance;

    // Item sees the top after this cycle's update
    assign nextTop = startNewTop ? bot : topReg;

    always_comb begin
        for (int p = 0; p < `PERM_COUNT; p++) begin
            permuted[p] = permuteBot(bot, permutePipePkg::permOrder'(p));
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            validReg <= 1'b0;
            topReg <= '0;
        end else if (outBus.advance) begin
            validReg <= inValid;
            if (accept && startNewTop) begin
                topReg <= bot;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            itemReg.bots <= permuted;
            itemReg.top <= nextTop;
            itemReg.startNewTop <= startNewTop;
        end
    end

    assign outBus.valid = validReg;
    assign outBus.payload = itemReg;

    // Stall comes from the output stage
    validHeldOnStall: assert property (@(posedge clock) disable iff (!rst)
        !outBus.advance |=> $stable(outBus.valid));

endmodule

/* source/subsetCounter.sv */
`timescale 1ns/10ps
`include "permutePipe_macros.svh"

module subsetCounter (
    input logic clock,
    input logic rst,
    permuteBus.sink inBus,
    permuteBus.source outBus
);

    localparam int ITEM_SUM_W = `ITEM_SUM_WIDTH;
    localparam int ITEM_COUNT_W = $clog2(`PERM_COUNT + 1);

    permutePipePkg::permutedItem inItem;
    permutePipePkg::countedItem itemReg;
    logic validReg;
    logic load;
    logic [`PERM_COUNT-1:0] isSubset;
    logic [`PERM_COUNT-1:0][ITEM_SUM_W-1:0] popCounts;
    logic [ITEM_SUM_W-1:0] sumNext;
    logic [ITEM_COUNT_W-1:0] countNext;

    assign inItem = inBus.payload;
    assign load = inBus.valid && inBus.advance;

    // Subset test and masked popcount per permutation
    always_comb begin
        for (int p = 0; p < `PERM_COUNT; p++) begin
            isSubset[p] = (inItem.bots[p] & ~inItem.top) == '0;
            popCounts[p] = ITEM_SUM_W'($countones(inItem.bots[p] & inItem.top));
        end
    end

    // Reduce the valid ones to one sum and one count
    always_comb begin
        sumNext = '0;
        countNext = '0;
        for (int p = 0; p < `PERM_COUNT; p++) begin
            if (isSubset[p]) begin
                sumNext = sumNext + popCounts[p];
                countNext = countNext + ITEM_COUNT_W'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            validReg <= 1'b0;
        end else if (inBus.advance) begin
            validReg <= inBus.valid;
        end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clock) begin
        if (load) begin
            itemReg.itemSum <= sumNext;
            itemReg.itemCount <= countNext;
            itemReg.startNewTop <= inItem.startNewTop;
        end
    end

    assign outBus.valid = validReg;
    assign outBus.payload = itemReg;

    // At most one hit per permutation
    countInRange: assert property (@(posedge clock) disable iff (!rst)
        validReg |-> itemReg.itemCount <= ITEM_COUNT_W'(`PERM_COUNT));

endmodule

/* source/topAccumulator.sv */
`timescale 1ns/10ps
`include "permutePipe_macros.svh"

module topAccumulator (
    input logic clock,
    input logic rst,
    input logic outReady,
    output logic inReady,
    permuteBus.sink inBus,
    output logic outValid,
    output logic [`SUM_WIDTH-1:0] summedData,
    output logic [`COUNT_WIDTH-1:0] pcoeffCount
);

    localparam int SUM_W = `SUM_WIDTH;
    localparam int COUNT_W = `COUNT_WIDTH;

    permutePipePkg::countedItem inItem;
    logic advance;
    logic load;
    logic outValidReg;
    logic [SUM_W-1:0] sumTotal;
    logic [SUM_W-1:0] sumNext;
    logic [COUNT_W-1:0] countTotal;
    logic [COUNT_W-1:0] countNext;

    assign inItem = inBus.payload;

    // Whole pipe moves when the output register is free or being read
    assign advance = !outValidReg || outReady;
    assign inReady = advance;
    assign load = advance && inBus.valid;

    // A new top restarts the totals from this item alone
    always_comb begin
        if (inItem.startNewTop) begin
            sumNext = SUM_W'(inItem.itemSum);
            countNext = COUNT_W'(inItem.itemCount);
        end else begin
            sumNext = sumTotal + SUM_W'(inItem.itemSum);
            countNext = countTotal + COUNT_W'(inItem.itemCount);
        end
    end

    always_ff @(posedge clock) begin
        if (!rst) begin
            outValidReg <= 1'b0;
        end else if (advance) begin
            outValidReg <= inBus.valid;
        end
    end

    // Totals double as the output register
    always_ff @(posedge clock) begin
        if (!rst) begin
            sumTotal <= '0;
            countTotal <= '0;
        end else if (load) begin
            sumTotal <= sumNext;
            countTotal <= countNext;
        end
    end

    assign outValid = outValidReg;
    assign summedData = sumTotal;
    assign pcoeffCount = countTotal;

    // Result must hold until the consumer takes it
    outputHeldOnStall: assert property (@(posedge clock) disable iff (!rst)
        outValid && !outReady |=> outValid && $stable(summedData) && $stable(pcoeffCount));

endmodule

/* source/permutePipelineTop.sv */
`timescale 1ns/10ps
`include "permutePipe_macros.svh"

module permutePipelineTop (
    input logic clock,
    input logic rst,
    input logic inValid,
    input logic startNewTop,
    input logic [`BOT_WIDTH-1:0] bot,
    input logic outReady,
    output logic inReady,
    output logic outValid,
    output logic [`SUM_WIDTH-1:0] summedData,
    output logic [`COUNT_WIDTH-1:0] pcoeffCount
);

    // Both buses share the stall from the output stage
    permuteBus #(
        .payloadType(permutePipePkg::permutedItem)
    ) permBus (
        .advance(inReady)
    );

    permuteBus #(
        .payloadType(permutePipePkg::countedItem)
    ) countBus (
        .advance(inReady)
    );

    // Stage 1, top register and permutations
    variablePermuter permuter (
        .clock(clock),
        .rst(rst),
        .inValid(inValid),
        .startNewTop(startNewTop),
        .bot(bot),
        .outBus(permBus.source)
    );

    // Stage 2, subset test and per-item reduction
    subsetCounter counter (
        .clock(clock),
        .rst(rst),
        .inBus(permBus.sink),
        .outBus(countBus.source)
    );

    // Stage 3, running totals and output handshake
    topAccumulator accumulator (
        .clock(clock),
        .rst(rst),
        .outReady(outReady),
        .inReady(inReady),
        .inBus(countBus.sink),
        .outValid(outValid),
        .summedData(summedData),
        .pcoeffCount(pcoeffCount)
    );

endmodule

/* verif/permutePipeTb.sv */
`timescale 1ns/10ps
`include "permutePipe_macros.svh"

module permutePipeTb;

    localparam int ITEM_TOTAL = 300;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int LATENCY = 3;

    typedef struct packed {
        logic [`SUM_WIDTH-1:0] sum;
        logic [`COUNT_WIDTH-1:0] count;
    } totals;

    logic clock = 1'b0;
    logic rst;
    logic inValid;
    logic startNewTop;
    logic [`BOT_WIDTH-1:0] bot;
    logic outReady = 1'b1;
    logic inReady;
    logic outValid;
    logic [`SUM_WIDTH-1:0] summedData;
    logic [`COUNT_WIDTH-1:0] pcoeffCount;

    integer seed = 32'hd4cd;
    integer stallSeed = 32'hd4cd;
    int cycle = 0;
    int firstInCycle = -1;
    int checkedCount = 0;
    bit firstOutSeen = 1'b0;
    bit stallEnable = 1'b0;
    bit stalledBefore = 1'b0;
    logic [`SUM_WIDTH-1:0] heldSum = '0;
    logic [`COUNT_WIDTH-1:0] heldCount = '0;
    logic [`BOT_WIDTH-1:0] modelTop = '0;
    totals modelTotals = '0;
    totals popped;
    totals expectedQ[$];

    permutePipelineTop DUT (
        .clock(clock),
        .rst(rst),
        .inValid(inValid),
        .startNewTop(startNewTop),
        .bot(bot),
        .outReady(outReady),
        .inReady(inReady),
        .outValid(outValid),
        .summedData(summedData),
        .pcoeffCount(pcoeffCount)
    );

    always #20 clock = !clock;

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    // Source variable that lands on position 4 + pos
    function automatic int landingVar(input permutePipePkg::permOrder order, input int pos);
        logic [11:0] code;
        case (order)
            permutePipePkg::PERM_465: code = 12'h465;
            permutePipePkg::PERM_546: code = 12'h546;
            permutePipePkg::PERM_564: code = 12'h564;
            permutePipePkg::PERM_645: code = 12'h645;
            permutePipePkg::PERM_654: code = 12'h654;
            default: code = 12'h456;
        endcase
        return int'(code[4 * (2 - pos) +: 4]);
    endfunction

    function automatic logic [`BOT_WIDTH-1:0] permuteRef(
        input logic [`BOT_WIDTH-1:0] source,
        input permutePipePkg::permOrder order
    );
        logic [`BOT_WIDTH-1:0] result;
        logic [6:0] outIdx;
        logic [6:0] srcIdx;
        for (int i = 0; i < `BOT_WIDTH; i++) begin
            outIdx = 7'(i);
            srcIdx = outIdx;
            for (int pos = 0; pos < 3; pos++) begin
                srcIdx[landingVar(order, pos)] = outIdx[4 + pos];
            end
            result[i] = source[srcIdx];
        end
        return result;
    endfunction

    // Expected totals after one item under the given top
    function automatic totals refItem(
        input logic [`BOT_WIDTH-1:0] itemBot,
        input logic [`BOT_WIDTH-1:0] top,
        input totals previous
    );
        totals result;
        logic [`BOT_WIDTH-1:0] p;
        result = previous;
        for (int k = 0; k < `PERM_COUNT; k++) begin
            p = permuteRef(itemBot, permutePipePkg::permOrder'(k));
            if ((p & ~top) == '0) begin
                result.sum = result.sum + `SUM_WIDTH'($countones(p & top));
                result.count = result.count + `COUNT_WIDTH'(1);
            end
        end
        return result;
    endfunction

    function automatic int randomBelow(input int limit);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(limit));
    endfunction

    function automatic logic [`BOT_WIDTH-1:0] randomWide();
        logic [`BOT_WIDTH-1:0] value;
        for (int w = 0; w < `BOT_WIDTH / 32; w++) begin
            value[32 * w +: 32] = $random(seed);
        end
        return value;
    endfunction

    // Dense top with about three bits in four set
    function automatic logic [`BOT_WIDTH-1:0] denseTop();
        return randomWide() | randomWide();
    endfunction

    function automatic logic [`BOT_WIDTH-1:0] makeBot(input logic [`BOT_WIDTH-1:0] top);
        logic [`BOT_WIDTH-1:0] value;
        int pick;
        int masks;
        pick = randomBelow(8);
        masks = 2 + randomBelow(3);
        value = top;
        if (pick == 0) begin
            // Permuted copy of the top
            value = permuteRef(top, permutePipePkg::permOrder'(randomBelow(`PERM_COUNT)));
        end else if (pick > 1) begin
            // Sparse subset so several permutations fit
            for (int m = 0; m < masks; m++) begin
                value = value & randomWide();
            end
        end
        return value;
    endfunction

    task automatic failNow(input string reason);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic checkValue(
        input string testName,
        input logic [63:0] expected,
        input logic [63:0] actual
    );
        if (expected !== actual) begin
            $display("ERROR: %s expected %0h actual %0h", testName, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "Value mismatch in %s", testName);
        end
    endtask

    // Called at posedge + 2 and returns at posedge + 2 after the transfer
    task automatic sendItem(input logic newTop, input logic [`BOT_WIDTH-1:0] itemBot);
        int waited;
        totals previous;
        inValid = 1'b1;
        startNewTop = newTop;
        bot = itemBot;
        waited = 0;
        @(negedge clock);
        while (!inReady) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                failNow("Input was never accepted by the pipeline");
            end
            @(negedge clock);
        end
        // Transfer on the coming rising edge
        if (newTop) begin
            modelTop = itemBot;
            previous = '0;
        end else begin
            previous = modelTotals;
        end
        modelTotals = refItem(itemBot, modelTop, previous);
        expectedQ.push_back(modelTotals);
        if (firstInCycle < 0) begin
            firstInCycle = cycle;
        end
        @(posedge clock);
        #2;
        inValid = 1'b0;
    endtask

    // Back-pressure in random stretches
    always @(posedge clock) begin
        #2;
        if (!stallEnable) begin
            outReady = 1'b1;
        end else if (($random(stallSeed) & 3) == 0) begin
            outReady = !outReady;
        end
    end

    // Output side sampled mid-cycle
    always @(negedge clock) begin
        if (rst) begin
            // Input side may only move when the output slot is free or being read
            checkValue("input ready", 64'(!outValid || outReady), 64'(inReady));
            if (stalledBefore) begin
                checkValue("stall hold valid", 64'(1), 64'(outValid));
                checkValue("stall hold sum", 64'(heldSum), 64'(summedData));
                checkValue("stall hold count", 64'(heldCount), 64'(pcoeffCount));
            end
            if (outValid && !firstOutSeen) begin
                firstOutSeen = 1'b1;
                if (firstInCycle < 0) begin
                    failNow("Output became valid before any input was accepted");
                end else begin
                    checkValue("first result latency", 64'(LATENCY), 64'(cycle - firstInCycle));
                end
            end
            if (outValid && outReady) begin
                if (expectedQ.size() == 0) begin
                    failNow("Output transferred with no pending input item");
                end else begin
                    popped = expectedQ.pop_front();
                    checkValue("running sum", 64'(popped.sum), 64'(summedData));
                    checkValue("pcoeff count", 64'(popped.count), 64'(pcoeffCount));
                    checkedCount++;
                end
            end
            stalledBefore = outValid && !outReady;
            heldSum = summedData;
            heldCount = pcoeffCount;
        end
    end

    initial begin
        int waited;
        int gap;
        logic newTop;
        rst = 1'b0;
        inValid = 1'b0;
        startNewTop = 1'b0;
        bot = '0;
        repeat (5) @(posedge clock);
        #2;
        rst = 1'b1;
        // Idle after reset so outValid has to stay low
        repeat (4) begin
            @(posedge clock);
            #2;
        end
        sendItem(1'b1, denseTop());
        for (int n = 1; n < ITEM_TOTAL; n++) begin
            if (n == 8) begin
                stallEnable = 1'b1;
            end
            gap = randomBelow(4);
            repeat (gap) begin
                @(posedge clock);
                #2;
            end
            newTop = (randomBelow(8) == 0);
            if (newTop) begin
                sendItem(1'b1, denseTop());
            end else begin
                sendItem(1'b0, makeBot(modelTop));
            end
        end
        stallEnable = 1'b0;
        waited = 0;
        while (checkedCount < ITEM_TOTAL) begin
            if (waited > TIMEOUT_CYCLES) begin
                failNow("Timed out waiting for the remaining results");
            end
            @(negedge clock);
            waited++;
        end
        if (expectedQ.size() == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            failNow("Expected results were left unchecked at the end of the run");
        end
    end

endmodule

/* permutePipe.f */
+incdir+source
source/permutePipePkg.sv
source/permuteBus.sv
source/variablePermuter.sv
source/subsetCounter.sv
source/topAccumulator.sv
source/permutePipelineTop.sv
verif/permutePipeTb.sv

/* runSim.sh */
#!/bin/sh
# Build the pipeline testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module permutePipeTb \
    -f permutePipe.f \
    -Mdir obj_dir \
    && ./obj_dir/VpermutePipeTb \
    || exit 1
